//--- flist.f
mem_cfg_pkg.sv
mem_req_pkg.sv
sram_bank.sv
bank_req_split.sv
bank_xbar.sv
rd_resp_buffer.sv
mem_banked_top.sv
mem_banked_checker.sv
tb_mem_banked.sv

//--- Makefile
# Verilator build and run of the banked scratchpad testbench
TOP := tb_mem_banked

.PHONY: all compile run clean

all: run

compile: obj_dir/V$(TOP)

obj_dir/V$(TOP): flist.f $(shell cat flist.f)
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f flist.f

# The log decides the result
run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) +verilator+error+limit+100 > sim.log 2>&1 || true
	cat sim.log
	@if grep -q "Something failed" sim.log; then echo "Simulation failed"; exit 1; fi
	@grep -q "Everything OK" sim.log || (echo "Simulation ended early"; exit 1)

clean:
	rm -rf obj_dir sim.log

//--- tb_mem_banked.sv
// ##########################################################
// Banked scratchpad testbench with stimulus and byte model
// Response checker and watchdog
// ##########################################################
`timescale 1ns/100ps

module tb_mem_banked
  import mem_cfg_pkg::*;
  import mem_req_pkg::*;
();

  localparam int CLK_PERIOD = 10;
  localparam int N_FILL     = 64;
  localparam int N_RAND     = 40;
  localparam int N_CONT     = 32;
  localparam int RDY_LEN    = 64;
  // Reads and writes over all phases including readback
  localparam int NUM_OPS    = 2 * N_FILL + 3 * N_RAND + 3 * N_CONT + 20;

  logic       clk;
  logic       rst;
  logic       wr_valid;
  logic       wr_ready;
  byte_addr_t wr_addr;
  wide_data_t wr_data;
  wide_strb_t wr_strb;
  logic       rd_valid;
  logic       rd_ready;
  byte_addr_t rd_addr;
  logic       rd_rvalid;
  logic       rd_rready;
  wide_data_t rd_rdata;

  // Byte model of the 4 KiB that the bank words cover
  logic [7:0]  model_mem [4096];
  // Expected responses in request order
  wide_data_t  exp_q [$];
  // Written addresses still to be read back
  byte_addr_t  wr_log [$];
  byte_addr_t  rnd_waddr [N_RAND];
  wide_data_t  rnd_wdata [N_RAND];
  wide_strb_t  rnd_wstrb [N_RAND];
  byte_addr_t  rnd_raddr [N_RAND];
  logic [RDY_LEN-1:0] rdy_pat;
  integer      seed;
  logic [31:0] r;
  wide_data_t  wd;

  mem_banked_top dut (
    .clk_i       (clk),
    .rst_i       (rst),
    .wr_valid_i  (wr_valid),
    .wr_ready_o  (wr_ready),
    .wr_addr_i   (wr_addr),
    .wr_data_i   (wr_data),
    .wr_strb_i   (wr_strb),
    .rd_valid_i  (rd_valid),
    .rd_ready_o  (rd_ready),
    .rd_addr_i   (rd_addr),
    .rd_rvalid_o (rd_rvalid),
    .rd_rready_i (rd_rready),
    .rd_rdata_o  (rd_rdata)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // Expected wide word with lane 0 in the low half and bits 15:12 aliased
  function automatic wide_data_t expected_word(byte_addr_t addr);
    wide_data_t w;
    for (int k = 0; k < WIDE_BYTES; k++) begin
      w[k*8 +: 8] = model_mem[{addr[11:3], 3'(k)}];
    end
    return w;
  endfunction

  // Only strobed bytes change
  task automatic model_write(byte_addr_t addr, wide_data_t data, wide_strb_t strb);
    for (int k = 0; k < WIDE_BYTES; k++) begin
      if (strb[k]) begin
        model_mem[{addr[11:3], 3'(k)}] = data[k*8 +: 8];
      end
    end
  endtask

  task automatic abort_run();
    $display("Something failed");
    $fatal(1, "Run stopped at the first error");
  endtask

  task automatic check_data(string name, wide_data_t got, wide_data_t exp);
    if (got !== exp) begin
      $display("FAILED at %0t ns: %s is %h, expected %h", $time, name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_bit(string name, logic got, logic exp);
    if (got !== exp) begin
      $display("FAILED at %0t ns: %s is %b, expected %b", $time, name, got, exp);
      abort_run();
    end
  endtask

  // Starts on a falling edge and returns on the one after the transfer
  task automatic write_word(byte_addr_t addr, wide_data_t data, wide_strb_t strb);
    wr_valid = 1'b1;
    wr_addr  = addr;
    wr_data  = data;
    wr_strb  = strb;
    do @(posedge clk); while (!wr_ready);
    @(negedge clk);
    wr_valid = 1'b0;
  endtask

  task automatic read_word(byte_addr_t addr);
    rd_valid = 1'b1;
    rd_addr  = addr;
    do @(posedge clk); while (!rd_ready);
    @(negedge clk);
    rd_valid = 1'b0;
  endtask

  task automatic drain_reads();
    while (exp_q.size() != 0) begin
      @(negedge clk);
    end
  endtask

  // Model update and response check at each handshake
  always @(posedge clk) begin
    if (!rst) begin
      if (wr_valid && wr_ready) begin
        model_write(wr_addr, wr_data, wr_strb);
      end
      if (rd_valid && rd_ready) begin
        exp_q.push_back(expected_word(rd_addr));
      end
      if (rd_rvalid && rd_rready) begin
        if (exp_q.size() == 0) begin
          $display("A read response arrived with no read outstanding");
          abort_run();
        end else begin
          check_data("rd_rdata_o", rd_rdata, exp_q.pop_front());
        end
      end
      if (dut.u_rd_resp_buffer.u_checker.fail_cnt != 0) begin
        $display("An assertion on the read response buffer failed");
        abort_run();
      end
    end
  end

  // Watchdog sized from the operation count
  initial begin
    #((NUM_OPS * 20 + 8) * CLK_PERIOD);
    $display("Timeout: the run did not finish within %0d cycles", NUM_OPS * 20 + 8);
    abort_run();
  end

  initial begin
    seed      = 32'h2e65;
    rst       = 1'b1;
    wr_valid  = 1'b0;
    wr_addr   = '0;
    wr_data   = '0;
    wr_strb   = '0;
    rd_valid  = 1'b0;
    rd_addr   = '0;
    rd_rready = 1'b1;
    repeat (8) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    // Idle levels after reset and a write beside a read on other banks
    check_bit("rd_rvalid_o", rd_rvalid, 1'b0);
    write_word(16'h0008, 64'h0123_4567_89ab_cdef, 8'hff);
    fork
      write_word(16'h0000, 64'hfedc_ba98_7654_3210, 8'hff);
      read_word(16'h0008);
      begin
        @(posedge clk);
        check_bit("wr_ready_o", wr_ready, 1'b1);
        check_bit("rd_ready_o", rd_ready, 1'b1);
      end
    join
    drain_reads();

    // Full-strobe fill and in-order readback
    for (int i = 0; i < N_FILL; i++) begin
      wd[31:0]  = $random(seed);
      wd[63:32] = $random(seed);
      write_word({7'h00, 6'(i), 3'b000}, wd, 8'hff);
    end
    for (int i = 0; i < N_FILL; i++) begin
      read_word({7'h00, 6'(i), 3'b000});
    end
    drain_reads();

    // Partial strobes on both lanes
    write_word(16'h0c00, 64'hffff_ffff_ffff_ffff, 8'hff);
    write_word(16'h0c00, 64'h1122_3344_5566_7788, 8'b1010_0110);
    read_word(16'h0c00);
    // Upper address bits alias
    write_word(16'h7c40, 64'h0bad_f00d_cafe_d00d, 8'hff);
    read_word(16'h1c40);
    write_word(16'h3c40, 64'h5a5a_5a5a_a5a5_a5a5, 8'b0011_1100);
    read_word(16'hfc40);
    drain_reads();

    // Stalled responses use up the credits
    rd_rready = 1'b0;
    for (int i = 0; i < RESP_DEPTH; i++) begin
      read_word({7'h00, 6'(i), 3'b000});
    end
    rd_valid = 1'b1;
    rd_addr  = 16'h0100;
    repeat (3) begin
      @(posedge clk);
      check_bit("rd_ready_o", rd_ready, 1'b0);
    end
    @(negedge clk);
    rd_rready = 1'b1;
    do @(posedge clk); while (!rd_ready);
    @(negedge clk);
    rd_valid = 1'b0;
    drain_reads();

    // Random writes near 0x800 against reads from the filled range
    for (int i = 0; i < N_RAND; i++) begin
      r = $random(seed);
      rnd_waddr[i] = {r[31:28], 3'b100, r[5:0], 3'b000};
      rnd_wstrb[i] = r[15:8];
      rnd_wdata[i][31:0]  = $random(seed);
      rnd_wdata[i][63:32] = $random(seed);
      r = $random(seed);
      rnd_raddr[i] = {r[31:28], 3'b000, r[5:0], 3'b000};
      wr_log.push_back(rnd_waddr[i]);
    end
    for (int c = 0; c < RDY_LEN; c++) begin
      r = $random(seed);
      rdy_pat[c] = (r[1:0] != 2'b00);
    end
    fork
      for (int i = 0; i < N_RAND; i++) write_word(rnd_waddr[i], rnd_wdata[i], rnd_wstrb[i]);
      for (int i = 0; i < N_RAND; i++) read_word(rnd_raddr[i]);
      begin
        for (int c = 0; c < RDY_LEN; c++) begin
          rd_rready = rdy_pat[c];
          @(negedge clk);
        end
        rd_rready = 1'b1;
      end
    join
    drain_reads();

    // Back-to-back reads and writes both aimed at banks 0 and 1
    fork
      for (int i = 0; i < N_CONT; i++) begin
        wd[31:0]  = $random(seed);
        wd[63:32] = $random(seed);
        wr_log.push_back({4'h0, 3'b100, 5'(i), 1'b0, 3'b000});
        write_word({4'h0, 3'b100, 5'(i), 1'b0, 3'b000}, wd, 8'hff);
      end
      for (int i = 0; i < N_CONT; i++) read_word({7'h00, 5'(i), 1'b0, 3'b000});
    join
    drain_reads();

    // Readback of everything written in the last two phases
    while (wr_log.size() != 0) begin
      read_word(wr_log.pop_front());
    end
    drain_reads();

    // Assertions that fired on the last edges count as well
    if (dut.u_rd_resp_buffer.u_checker.fail_cnt == 0) begin
      $display("Everything OK");
      $finish;
    end else begin
      $display("An assertion on the read response buffer failed");
      abort_run();
    end
  end

endmodule

//--- mem_banked_checker.sv
// ##########################################################
// Concurrent assertions on the read response buffer
// ##########################################################
`timescale 1ns/100ps

module mem_banked_checker
  import mem_cfg_pkg::*;
  import mem_req_pkg::*;
(
  input logic                  clk_i,
  input logic                  rst_i,
  input logic                  rvalid_i,
  input logic                  rready_i,
  input wide_data_t            rdata_i,
  input logic [RESP_CNT_W-1:0] out_cnt_i
);

  // Failed assertions so far, watched from the testbench
  int fail_cnt = 0;

  // Stalled response keeps valid and data
  a_stall_hold: assert property (@(posedge clk_i) disable iff (rst_i)
    rvalid_i && !rready_i |=> rvalid_i && $stable(rdata_i))
  else begin
    fail_cnt++;
    $error("read response changed while stalled");
  end

  // Credits bound the outstanding reads
  a_cnt_bound: assert property (@(posedge clk_i) disable iff (rst_i)
    out_cnt_i <= RESP_CNT_W'(RESP_DEPTH))
  else begin
    fail_cnt++;
    $error("outstanding read count above the buffer depth");
  end

  // No response right out of reset
  a_reset_idle: assert property (@(posedge clk_i) rst_i |=> !rvalid_i)
  else begin
    fail_cnt++;
    $error("read response valid in the cycle after reset");
  end

endmodule

bind rd_resp_buffer mem_banked_checker u_checker (
  .clk_i     (clk_i),
  .rst_i     (rst_i),
  .rvalid_i  (rd_rvalid_o),
  .rready_i  (rd_rready_i),
  .rdata_i   (rd_rdata_o),
  .out_cnt_i (out_cnt_q)
);

//--- mem_banked_top.sv
// ##########################################################
// Banked scratchpad with parallel read and write ports
// ##########################################################
`timescale 1ns/100ps

module mem_banked_top
  import mem_cfg_pkg::*;
  import mem_req_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_i,
  // Write port
  input  logic       wr_valid_i,
  output logic       wr_ready_o,
  input  byte_addr_t wr_addr_i,
  input  wide_data_t wr_data_i,
  input  wide_strb_t wr_strb_i,
  // Read request
  input  logic       rd_valid_i,
  output logic       rd_ready_o,
  input  byte_addr_t rd_addr_i,
  // Read response
  output logic       rd_rvalid_o,
  input  logic       rd_rready_i,
  output wide_data_t rd_rdata_o
);

  // Gated read request
  logic rd_req_valid;
  logic rd_req_ready;

  // Crossbar inputs, read lanes low and write lanes high
  logic       [NUM_REQ-1:0]   in_valid;
  bank_sel_t  [NUM_REQ-1:0]   in_sel;
  word_addr_t [NUM_REQ-1:0]   in_addr;
  logic       [NUM_REQ-1:0]   in_we;
  lane_data_t [NUM_REQ-1:0]   in_data;
  lane_strb_t [NUM_REQ-1:0]   in_strb;
  logic       [NUM_REQ-1:0]   in_ready;

  // Bank side
  logic       [NUM_BANKS-1:0] bank_req;
  logic       [NUM_BANKS-1:0] bank_we;
  word_addr_t [NUM_BANKS-1:0] bank_addr;
  lane_data_t [NUM_BANKS-1:0] bank_wdata;
  lane_strb_t [NUM_BANKS-1:0] bank_be;
  lane_data_t [NUM_BANKS-1:0] bank_rdata;

  // Read data returning per lane
  logic       [NUM_LANES-1:0] rlane_valid;
  lane_data_t [NUM_LANES-1:0] rlane_data;

  rd_resp_buffer u_rd_resp_buffer (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .rd_valid_i    (rd_valid_i),
    .rd_ready_o    (rd_ready_o),
    .req_valid_o   (rd_req_valid),
    .req_ready_i   (rd_req_ready),
    .rlane_valid_i (rlane_valid),
    .rlane_data_i  (rlane_data),
    .rd_rvalid_o   (rd_rvalid_o),
    .rd_rready_i   (rd_rready_i),
    .rd_rdata_o    (rd_rdata_o)
  );

  // Read side carries no data or strobes
  bank_req_split #(.ACCESS(ACC_READ)) u_rd_split (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .req_valid_i  (rd_req_valid),
    .req_ready_o  (rd_req_ready),
    .req_addr_i   (rd_addr_i),
    .req_data_i   ('0),
    .req_strb_i   ('0),
    .lane_valid_o (in_valid[NUM_LANES-1:0]),
    .lane_sel_o   (in_sel[NUM_LANES-1:0]),
    .lane_addr_o  (in_addr[NUM_LANES-1:0]),
    .lane_we_o    (in_we[NUM_LANES-1:0]),
    .lane_data_o  (in_data[NUM_LANES-1:0]),
    .lane_strb_o  (in_strb[NUM_LANES-1:0]),
    .lane_ready_i (in_ready[NUM_LANES-1:0])
  );

  bank_req_split #(.ACCESS(ACC_WRITE)) u_wr_split (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .req_valid_i  (wr_valid_i),
    .req_ready_o  (wr_ready_o),
    .req_addr_i   (wr_addr_i),
    .req_data_i   (wr_data_i),
    .req_strb_i   (wr_strb_i),
    .lane_valid_o (in_valid[NUM_REQ-1:NUM_LANES]),
    .lane_sel_o   (in_sel[NUM_REQ-1:NUM_LANES]),
    .lane_addr_o  (in_addr[NUM_REQ-1:NUM_LANES]),
    .lane_we_o    (in_we[NUM_REQ-1:NUM_LANES]),
    .lane_data_o  (in_data[NUM_REQ-1:NUM_LANES]),
    .lane_strb_o  (in_strb[NUM_REQ-1:NUM_LANES]),
    .lane_ready_i (in_ready[NUM_REQ-1:NUM_LANES])
  );

  bank_xbar u_bank_xbar (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .in_valid_i    (in_valid),
    .in_sel_i      (in_sel),
    .in_addr_i     (in_addr),
    .in_we_i       (in_we),
    .in_data_i     (in_data),
    .in_strb_i     (in_strb),
    .in_ready_o    (in_ready),
    .bank_req_o    (bank_req),
    .bank_we_o     (bank_we),
    .bank_addr_o   (bank_addr),
    .bank_wdata_o  (bank_wdata),
    .bank_be_o     (bank_be),
    .bank_rdata_i  (bank_rdata),
    .rlane_valid_o (rlane_valid),
    .rlane_data_o  (rlane_data)
  );

  for (genvar b = 0; b < NUM_BANKS; b++) begin : gen_bank
    sram_bank u_sram_bank (
      .clk_i   (clk_i),
      .req_i   (bank_req[b]),
      .we_i    (bank_we[b]),
      .addr_i  (bank_addr[b]),
      .wdata_i (bank_wdata[b]),
      .be_i    (bank_be[b]),
      .rdata_o (bank_rdata[b])
    );
  end

endmodule

//--- rd_resp_buffer.sv
// ##########################################################
// Read credits, per-lane response FIFOs, wide data output
// ##########################################################
`timescale 1ns/100ps

module rd_resp_buffer
  import mem_cfg_pkg::*;
  import mem_req_pkg::*;
(
  input  logic                       clk_i,
  input  logic                       rst_i,
  // Read request from the port
  input  logic                       rd_valid_i,
  output logic                       rd_ready_o,
  // Gated request to the read splitter
  output logic                       req_valid_o,
  input  logic                       req_ready_i,
  // Returning lane words
  input  logic       [NUM_LANES-1:0] rlane_valid_i,
  input  lane_data_t [NUM_LANES-1:0] rlane_data_i,
  // Wide read response
  output logic                       rd_rvalid_o,
  input  logic                       rd_rready_i,
  output wide_data_t                 rd_rdata_o
);

  logic [RESP_CNT_W-1:0]      out_cnt_q;
  logic                       credit_free;
  logic                       rd_accept;
  logic                       rsp_taken;
  logic                       pop;
  logic [NUM_LANES-1:0]       lane_avail;
  lane_data_t [NUM_LANES-1:0] head_data;

  // Requests pass only while a credit is left
  assign credit_free = out_cnt_q < RESP_CNT_W'(RESP_DEPTH);
  assign req_valid_o = rd_valid_i & credit_free;
  assign rd_ready_o  = req_ready_i;
  assign rd_accept   = rd_valid_i & rd_ready_o;
  assign rsp_taken   = rd_rvalid_o & rd_rready_i;

  // Outstanding reads, from acceptance until the response is taken
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      out_cnt_q <= '0;
    end else if (rd_accept && !rsp_taken) begin
      out_cnt_q <= out_cnt_q + 1'b1;
    end else if (!rd_accept && rsp_taken) begin
      out_cnt_q <= out_cnt_q - 1'b1;
    end
  end

  // Both lanes present and the output slot free or leaving
  assign pop = (&lane_avail) & (~rd_rvalid_o | rd_rready_i);

  for (genvar j = 0; j < NUM_LANES; j++) begin : gen_fifo
    lane_data_t            fifo_q [RESP_DEPTH];
    logic [RESP_PTR_W-1:0] wr_ptr_q;
    logic [RESP_PTR_W-1:0] rd_ptr_q;
    logic [RESP_CNT_W-1:0] fill_q;

    assign lane_avail[j] = (fill_q != '0);
    assign head_data[j]  = fifo_q[rd_ptr_q];

    always_ff @(posedge clk_i) begin
      if (rst_i) begin
        wr_ptr_q <= '0;
        rd_ptr_q <= '0;
        fill_q   <= '0;
      end else begin
        if (rlane_valid_i[j]) begin
          wr_ptr_q <= wr_ptr_q + 1'b1;
        end
        if (pop) begin
          rd_ptr_q <= rd_ptr_q + 1'b1;
        end
        // Credits keep the fill at or below RESP_DEPTH
        if (rlane_valid_i[j] && !pop) begin
          fill_q <= fill_q + 1'b1;
        end else if (!rlane_valid_i[j] && pop) begin
          fill_q <= fill_q - 1'b1;
        end
      end
    end

    // Word enters in its return cycle
    always_ff @(posedge clk_i) begin
      if (rlane_valid_i[j]) begin
        fifo_q[wr_ptr_q] <= rlane_data_i[j];
      end
    end
  end

  // Output register, held while stalled
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rd_rvalid_o <= 1'b0;
    end else if (pop) begin
      rd_rvalid_o <= 1'b1;
    end else if (rsp_taken) begin
      rd_rvalid_o <= 1'b0;
    end
  end

  // Lane 0 lands in the low half
  always_ff @(posedge clk_i) begin
    if (pop) begin
      rd_rdata_o <= head_data;
    end
  end

endmodule

//--- bank_xbar.sv
// ##########################################################
// Per-bank round-robin crossbar and read data return
// ##########################################################
`timescale 1ns/100ps

module bank_xbar
  import mem_cfg_pkg::*;
  import mem_req_pkg::*;
(
  input  logic                       clk_i,
  input  logic                       rst_i,
  // Lane requests, read lanes low and write lanes high
  input  logic       [NUM_REQ-1:0]   in_valid_i,
  input  bank_sel_t  [NUM_REQ-1:0]   in_sel_i,
  input  word_addr_t [NUM_REQ-1:0]   in_addr_i,
  input  logic       [NUM_REQ-1:0]   in_we_i,
  input  lane_data_t [NUM_REQ-1:0]   in_data_i,
  input  lane_strb_t [NUM_REQ-1:0]   in_strb_i,
  output logic       [NUM_REQ-1:0]   in_ready_o,
  // Bank side
  output logic       [NUM_BANKS-1:0] bank_req_o,
  output logic       [NUM_BANKS-1:0] bank_we_o,
  output word_addr_t [NUM_BANKS-1:0] bank_addr_o,
  output lane_data_t [NUM_BANKS-1:0] bank_wdata_o,
  output lane_strb_t [NUM_BANKS-1:0] bank_be_o,
  input  lane_data_t [NUM_BANKS-1:0] bank_rdata_i,
  // Read data back to the read lanes
  output logic       [NUM_LANES-1:0] rlane_valid_o,
  output lane_data_t [NUM_LANES-1:0] rlane_data_o
);

  // One-hot grant per bank over all inputs
  logic [NUM_BANKS-1:0][NUM_REQ-1:0] bank_gnt;

  for (genvar b = 0; b < NUM_BANKS; b++) begin : gen_bank
    logic [NUM_REQ-1:0]   match;
    logic [REQ_IDX_W-1:0] rr_ptr_q;
    logic [REQ_IDX_W-1:0] win;
    logic                 found;

    // Inputs that want this bank
    for (genvar i = 0; i < NUM_REQ; i++) begin : gen_match
      assign match[i] = in_valid_i[i] && (in_sel_i[i] == bank_sel_t'(b));
    end

    // First match at or after the pointer wins
    always_comb begin
      logic [REQ_IDX_W-1:0] idx;
      found = 1'b0;
      win   = rr_ptr_q;
      for (int k = 0; k < NUM_REQ; k++) begin
        // Input count is a power of two, so the index wraps by itself
        idx = rr_ptr_q + REQ_IDX_W'(k);
        if (!found && match[idx]) begin
          found = 1'b1;
          win   = idx;
        end
      end
    end

    // Pointer moves past the winner
    always_ff @(posedge clk_i) begin
      if (rst_i) begin
        rr_ptr_q <= '0;
      end else if (found) begin
        rr_ptr_q <= win + 1'b1;
      end
    end

    assign bank_gnt[b] = found ? (NUM_REQ'(1) << win) : '0;

    // Bank always accepts, so the winner goes straight through
    assign bank_req_o[b]   = found;
    assign bank_we_o[b]    = in_we_i[win];
    assign bank_addr_o[b]  = in_addr_i[win];
    assign bank_wdata_o[b] = in_data_i[win];
    assign bank_be_o[b]    = in_strb_i[win];
  end

  // Ready of an input is its grant from the bank it selects
  for (genvar i = 0; i < NUM_REQ; i++) begin : gen_ready
    assign in_ready_o[i] = bank_gnt[in_sel_i[i]][i];
  end

  // Read lanes occupy the low crossbar inputs
  for (genvar j = 0; j < NUM_LANES; j++) begin : gen_rlane
    bank_sel_t              sel_q [MEM_LATENCY];
    logic [MEM_LATENCY-1:0] vld_q;

    // Valid bit of the bank select pipe
    always_ff @(posedge clk_i) begin
      if (rst_i) begin
        vld_q <= '0;
      end else begin
        vld_q[0] <= in_valid_i[j] & in_ready_o[j];
        for (int s = 1; s < MEM_LATENCY; s++) begin
          vld_q[s] <= vld_q[s-1];
        end
      end
    end

    // Bank index travels with the read until its data returns
    always_ff @(posedge clk_i) begin
      sel_q[0] <= in_sel_i[j];
      for (int s = 1; s < MEM_LATENCY; s++) begin
        sel_q[s] <= sel_q[s-1];
      end
    end

    assign rlane_valid_o[j] = vld_q[MEM_LATENCY-1];
    assign rlane_data_o[j]  = bank_rdata_i[sel_q[MEM_LATENCY-1]];
  end

endmodule

//--- bank_req_split.sv
// ##########################################################
// Splits a wide request into per-lane bank requests
// ##########################################################
`timescale 1ns/100ps

module bank_req_split
  import mem_cfg_pkg::*;
  import mem_req_pkg::*;
#(
  parameter access_e ACCESS = ACC_READ
) (
  input  logic                         clk_i,
  input  logic                         rst_i,
  // Wide request
  input  logic                         req_valid_i,
  output logic                         req_ready_o,
  input  byte_addr_t                   req_addr_i,
  input  wide_data_t                   req_data_i,
  input  wide_strb_t                   req_strb_i,
  // Per-lane bank requests
  output logic       [NUM_LANES-1:0]   lane_valid_o,
  output bank_sel_t  [NUM_LANES-1:0]   lane_sel_o,
  output word_addr_t [NUM_LANES-1:0]   lane_addr_o,
  output logic       [NUM_LANES-1:0]   lane_we_o,
  output lane_data_t [NUM_LANES-1:0]   lane_data_o,
  output lane_strb_t [NUM_LANES-1:0]   lane_strb_o,
  input  logic       [NUM_LANES-1:0]   lane_ready_i
);

  // Lanes already granted for the current request
  logic [NUM_LANES-1:0] lane_done_q;
  logic [NUM_LANES-1:0] lane_gnt;

  for (genvar j = 0; j < NUM_LANES; j++) begin : gen_lane
    // Bank is address bit 3 above the lane index
    assign lane_sel_o[j]  = {req_addr_i[LANE_OFFSET + LANE_SEL_W +: BANK_SEL_W - LANE_SEL_W],
                             LANE_SEL_W'(j)};
    // Word address sits right above the bank select, bits 11:4
    assign lane_addr_o[j] = req_addr_i[LANE_OFFSET + BANK_SEL_W +: BANK_ADDR_W];
    assign lane_data_o[j] = req_data_i[j*LANE_W +: LANE_W];
    assign lane_strb_o[j] = req_strb_i[j*LANE_BYTES +: LANE_BYTES];
    // Write enable fixed by the port kind
    assign lane_we_o[j]   = (ACCESS == ACC_WRITE);
  end

  // A granted lane is never issued again
  assign lane_valid_o = {NUM_LANES{req_valid_i}} & ~lane_done_q;
  assign lane_gnt     = lane_valid_o & lane_ready_i;

  // Request completes once every lane is done or granted now
  assign req_ready_o  = req_valid_i & (&(lane_done_q | lane_gnt));

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      lane_done_q <= '0;
    end else if (req_ready_o) begin
      // Last lane granted, start clean for the next request
      lane_done_q <= '0;
    end else begin
      lane_done_q <= lane_done_q | lane_gnt;
    end
  end

endmodule

//--- sram_bank.sv
// ##########################################################
// Single word-addressed SRAM bank with byte enables
// ##########################################################
`timescale 1ns/100ps

module sram_bank
  import mem_cfg_pkg::*;
  import mem_req_pkg::*;
(
  input  logic       clk_i,
  input  logic       req_i,
  input  logic       we_i,
  input  word_addr_t addr_i,
  input  lane_data_t wdata_i,
  input  lane_strb_t be_i,
  output lane_data_t rdata_o
);

  // Storage array, contents undefined after power up
  lane_data_t mem_q [2**BANK_ADDR_W];

  always_ff @(posedge clk_i) begin
    if (req_i) begin
      if (we_i) begin
        // Only the enabled bytes change
        for (int k = 0; k < LANE_BYTES; k++) begin
          if (be_i[k]) begin
            mem_q[addr_i][k*8 +: 8] <= wdata_i[k*8 +: 8];
          end
        end
      end else begin
        // Read word shows one cycle after the request
        rdata_o <= mem_q[addr_i];
      end
    end
  end

endmodule

//--- mem_req_pkg.sv
// ##########################################################
// Address, data, strobe and select types
// Access kind enum for the crossbar ports
// ##########################################################
package mem_req_pkg;

  import mem_cfg_pkg::*;

  // Access kind, also the port index on the crossbar inputs
  typedef enum logic {
    ACC_READ  = 1'b0,
    ACC_WRITE = 1'b1
  } access_e;

  // Port byte address, bits 2:0 ignored
  typedef logic [BYTE_ADDR_W-1:0] byte_addr_t;

  // Word address inside one bank
  typedef logic [BANK_ADDR_W-1:0] word_addr_t;

  // Bank index
  typedef logic [BANK_SEL_W-1:0]  bank_sel_t;

  // One lane word and its byte enables
  typedef logic [LANE_W-1:0]      lane_data_t;
  typedef logic [LANE_BYTES-1:0]  lane_strb_t;

  // Wide port data and byte enables
  typedef logic [WIDE_W-1:0]      wide_data_t;
  typedef logic [WIDE_BYTES-1:0]  wide_strb_t;

endpackage

//--- mem_cfg_pkg.sv
// ##########################################################
// Size, bank count, latency and buffer depth constants
// of the banked scratchpad
// ##########################################################
package mem_cfg_pkg;

  // One bank word and its byte enables
  localparam int unsigned LANE_W      = 32;
  localparam int unsigned LANE_BYTES  = LANE_W / 8;

  // Lanes per wide access and the lane index width
  localparam int unsigned NUM_LANES   = 2;
  localparam int unsigned LANE_SEL_W  = 1;
  localparam int unsigned WIDE_W      = LANE_W * NUM_LANES;
  localparam int unsigned WIDE_BYTES  = WIDE_W / 8;

  // Bank set, a power of two and at least twice the lane count
  localparam int unsigned NUM_BANKS   = 4;
  localparam int unsigned BANK_SEL_W  = 2;
  // Byte offset bits inside one lane word
  localparam int unsigned LANE_OFFSET = 2;
  localparam int unsigned BANK_ADDR_W = 8;
  localparam int unsigned BYTE_ADDR_W = 16;

  // SRAM read latency in cycles
  localparam int unsigned MEM_LATENCY = 1;

  // Outstanding reads, counter and FIFO pointer widths
  localparam int unsigned RESP_DEPTH  = 4;
  localparam int unsigned RESP_CNT_W  = 3;
  localparam int unsigned RESP_PTR_W  = 2;

  // Crossbar inputs, read lanes first and write lanes after
  localparam int unsigned NUM_REQ     = 2 * NUM_LANES;
  localparam int unsigned REQ_IDX_W   = 2;

endpackage
